//--- Bender.yml
package:
  name: uart_wb

sources:
  - files:
      - rtl/uart_reg_pkg.sv
      - rtl/uart_line_pkg.sv
      - rtl/uart_fifo.sv
      - rtl/uart_baud_gen.sv
      - rtl/uart_wb_regs.sv
      - rtl/uart_tx.sv
      - rtl/uart_rx.sv
      - rtl/uart_top.sv
  - target: simulation
    files:
      - verif/uart_tb.sv

//--- build.f
rtl/uart_reg_pkg.sv
rtl/uart_line_pkg.sv
rtl/uart_fifo.sv
rtl/uart_baud_gen.sv
rtl/uart_wb_regs.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_top.sv
verif/uart_tb.sv

//--- rtl/uart_baud_gen.sv
// Oversampling tick generator
// Pulses tick for one clock every divisor+1 clocks

`timescale 1ns/1ps

module uart_baud_gen (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] divisor,
    output logic        tick
);

    logic [15:0] cnt;

    // New divisor is picked up only on reload
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            cnt <= '0;
        else if (cnt == '0)
            cnt <= divisor;
        else
            cnt <= cnt - 1'b1;
    end

    assign tick = (cnt == '0);

endmodule

//--- rtl/uart_fifo.sv
// Small synchronous FIFO, payload set by a type parameter
// Used for the TX byte queue and the RX entry queue

`timescale 1ns/1ps

module uart_fifo #(
    parameter type entry_t = logic [7:0],
    parameter int  depth   = 4
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   push,
    input  entry_t push_data,
    input  logic   pop,
    output entry_t head,
    output logic   empty,
    output logic   full
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    entry_t           mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;   // Push while full is dropped
    assign do_pop  = pop && !empty;
    assign empty   = (count == '0);
    assign full    = (count == cnt_w'(depth));
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count <= cnt_w'(depth));

endmodule

//--- rtl/uart_line_pkg.sv
// Serial line format shared by the transmitter, receiver and FIFOs
// 8N1 frames at 16x oversampling, plus the receive FIFO entry layout

package uart_line_pkg;

    // ==================================================
    // Frame format
    // ==================================================
    localparam int data_bits  = 8;
    localparam int oversample = 16;  // Ticks per bit

    // Entries per direction
    localparam int fifo_depth = 4;

    // Received byte with its stop-bit check
    typedef struct packed {
        logic                 frame_err;
        logic [data_bits-1:0] data;
    } rx_entry_t;

endpackage

//--- rtl/uart_reg_pkg.sv
// Bus-side register map of the UART peripheral
// Offsets, STAT and CTRL bit positions, and the divisor reset value

package uart_reg_pkg;

    // ==================================================
    // Register offsets on a 4-bit byte address
    // ==================================================
    localparam int adr_width = 4;

    localparam logic [adr_width-1:0] reg_data = 4'h0;
    localparam logic [adr_width-1:0] reg_stat = 4'h4;
    localparam logic [adr_width-1:0] reg_ctrl = 4'h8;
    localparam logic [adr_width-1:0] reg_div  = 4'hC;

    // STAT bits
    localparam int stat_width     = 6;
    localparam int stat_rx_avail  = 0;
    localparam int stat_tx_empty  = 1;
    localparam int stat_tx_full   = 2;
    localparam int stat_rx_full   = 3;
    localparam int stat_frame_err = 4;  // Sticky, write one to clear
    localparam int stat_overrun   = 5;  // Sticky, write one to clear

    // CTRL bits
    localparam int ctrl_width  = 3;
    localparam int ctrl_tx_en  = 0;
    localparam int ctrl_rx_en  = 1;
    localparam int ctrl_irq_en = 2;

    // 100 MHz / (115200 * 16) - 1
    localparam int div_width = 16;
    localparam logic [div_width-1:0] div_reset = 16'd53;

endpackage

//--- rtl/uart_rx.sv
// 8N1 receiver with 16x oversampling
// Checks the start bit at mid-bit, samples data mid-bit, flags a low stop bit

`timescale 1ns/1ps

module uart_rx (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     tick,
    input  logic                     rx_en,
    input  logic                     rx,
    output logic                     push,
    output uart_line_pkg::rx_entry_t entry
);

    localparam int tick_w = $clog2(uart_line_pkg::oversample);
    localparam int half   = uart_line_pkg::oversample / 2;
    localparam int bit_w  = $clog2(uart_line_pkg::data_bits + 1);

    typedef enum logic [1:0] {st_idle, st_start, st_data} state_t;

    state_t                              state;
    logic [1:0]                          rx_sync;
    logic                                rx_s;
    logic                                rx_last;
    logic [tick_w-1:0]                   tick_cnt;
    logic [tick_w-1:0]                   tick_end;
    logic [bit_w-1:0]                    bit_cnt;
    logic [uart_line_pkg::data_bits-1:0] shift;
    logic                                sample;
    logic                                stop_bit;

    assign rx_s     = rx_sync[1];
    assign tick_end = (state == st_start) ? tick_w'(half - 1)
                                          : tick_w'(uart_line_pkg::oversample - 1);
    assign sample   = tick && (tick_cnt == tick_end);
    assign stop_bit = (bit_cnt == bit_w'(uart_line_pkg::data_bits));

    // Two-flop synchronizer, idles high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_sync <= 2'b11;
            rx_last <= 1'b1;
        end else begin
            rx_sync <= {rx_sync[0], rx};
            rx_last <= rx_s;
        end
    end

    // ==================================================
    // Frame FSM
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            push     <= 1'b0;
        end else begin
            push <= 1'b0;
            case (state)
                st_idle: begin
                    if (rx_en && rx_last && !rx_s) begin  // Falling edge
                        state    <= st_start;
                        tick_cnt <= '0;
                    end
                end
                st_start: begin
                    if (sample) begin
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_s ? st_idle : st_data;  // High means a glitch
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (sample) begin
                        tick_cnt <= '0;
                        if (stop_bit) begin
                            push  <= 1'b1;  // Even into a full FIFO
                            state <= st_idle;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_data && sample) begin
            if (stop_bit) begin
                entry.data      <= shift;
                entry.frame_err <= !rx_s;
            end else begin
                shift <= {rx_s, shift[uart_line_pkg::data_bits-1:1]};
            end
        end
    end

    a_push_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        push |=> !push);

endmodule

//--- rtl/uart_top.sv
// UART peripheral top level
// Wishbone register block, baud tick, TX and RX FIFOs and the two shifters

`timescale 1ns/1ps

module uart_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               wb_cyc,
    input  logic                               wb_stb,
    input  logic                               wb_we,
    input  logic [uart_reg_pkg::adr_width-1:0] wb_adr,
    input  logic [31:0]                        wb_dat_w,
    output logic [31:0]                        wb_dat_r,
    output logic                               wb_ack,
    input  logic                               rx,
    output logic                               tx,
    output logic                               irq
);

    logic [uart_line_pkg::data_bits-1:0] tx_data;
    logic [uart_line_pkg::data_bits-1:0] tx_head;
    logic                                tx_push;
    logic                                tx_pop;
    logic                                tx_empty;
    logic                                tx_full;
    uart_line_pkg::rx_entry_t            rx_entry;
    uart_line_pkg::rx_entry_t            rx_head;
    logic                                rx_push;
    logic                                rx_pop;
    logic                                rx_empty;
    logic                                rx_full;
    logic [uart_reg_pkg::div_width-1:0]  divisor;
    logic                                tick;
    logic                                tx_en;
    logic                                rx_en;

    uart_wb_regs regs_i (
        .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .tx_push, .tx_data, .tx_empty, .tx_full,
        .rx_pop, .rx_head, .rx_empty, .rx_full, .rx_push,
        .divisor, .tx_en, .rx_en, .irq
    );

    uart_baud_gen baud_i (.clk, .rst_n, .divisor, .tick);

    // Byte queue towards the line
    uart_fifo #(
        .entry_t (logic [uart_line_pkg::data_bits-1:0]),
        .depth   (uart_line_pkg::fifo_depth)
    ) tx_fifo_i (
        .clk, .rst_n, .push(tx_push), .push_data(tx_data), .pop(tx_pop),
        .head(tx_head), .empty(tx_empty), .full(tx_full)
    );

    uart_fifo #(
        .entry_t (uart_line_pkg::rx_entry_t),
        .depth   (uart_line_pkg::fifo_depth)
    ) rx_fifo_i (
        .clk, .rst_n, .push(rx_push), .push_data(rx_entry), .pop(rx_pop),
        .head(rx_head), .empty(rx_empty), .full(rx_full)
    );

    uart_tx tx_i (
        .clk, .rst_n, .tick, .tx_en,
        .fifo_empty(tx_empty), .fifo_head(tx_head), .fifo_pop(tx_pop), .tx
    );

    uart_rx rx_i (.clk, .rst_n, .tick, .rx_en, .rx, .push(rx_push), .entry(rx_entry));

endmodule

//--- rtl/uart_tx.sv
// 8N1 transmitter, pops bytes from the TX FIFO on a tick boundary
// Each bit is held for one oversampling period of 16 ticks

`timescale 1ns/1ps

module uart_tx (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                tick,
    input  logic                                tx_en,
    input  logic                                fifo_empty,
    input  logic [uart_line_pkg::data_bits-1:0] fifo_head,
    output logic                                fifo_pop,
    output logic                                tx
);

    localparam int frame_bits = uart_line_pkg::data_bits + 2;  // Start, data, stop
    localparam int tick_w     = $clog2(uart_line_pkg::oversample);
    localparam int bit_w      = $clog2(frame_bits);

    logic                  busy;
    logic [frame_bits-1:0] shift;
    logic [tick_w-1:0]     tick_cnt;
    logic [bit_w-1:0]      bit_cnt;
    logic                  bit_done;
    logic                  last_bit;
    logic                  load;

    assign bit_done = tick && (tick_cnt == tick_w'(uart_line_pkg::oversample - 1));
    assign last_bit = (bit_cnt == bit_w'(frame_bits - 1));
    // Next byte may follow straight after a stop bit
    assign load     = tick && tx_en && !fifo_empty && (!busy || (bit_done && last_bit));
    assign fifo_pop = load;
    assign tx       = busy ? shift[0] : 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else if (load) begin
            busy     <= 1'b1;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else if (busy && tick) begin
            tick_cnt <= tick_cnt + 1'b1;
            if (bit_done) begin
                tick_cnt <= '0;
                if (last_bit)
                    busy <= 1'b0;   // tx_en is not checked mid-frame
                else
                    bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load)
            shift <= {1'b1, fifo_head, 1'b0};
        else if (bit_done)
            shift <= {1'b1, shift[frame_bits-1:1]};  // LSB first
    end

    // Line drops to idle only from a high stop bit
    a_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
        !busy |-> $past(tx));

endmodule

//--- rtl/uart_wb_regs.sv
// Wishbone classic slave with the DATA, STAT, CTRL and DIV registers
// Feeds the TX FIFO, drains the RX FIFO and raises the RX interrupt

`timescale 1ns/1ps

module uart_wb_regs (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 wb_cyc,
    input  logic                                 wb_stb,
    input  logic                                 wb_we,
    input  logic [uart_reg_pkg::adr_width-1:0]   wb_adr,
    input  logic [31:0]                          wb_dat_w,
    output logic [31:0]                          wb_dat_r,
    output logic                                 wb_ack,
    output logic                                 tx_push,
    output logic [uart_line_pkg::data_bits-1:0]  tx_data,
    input  logic                                 tx_empty,
    input  logic                                 tx_full,
    output logic                                 rx_pop,
    input  uart_line_pkg::rx_entry_t             rx_head,
    input  logic                                 rx_empty,
    input  logic                                 rx_full,
    input  logic                                 rx_push,
    output logic [uart_reg_pkg::div_width-1:0]   divisor,
    output logic                                 tx_en,
    output logic                                 rx_en,
    output logic                                 irq
);

    logic [uart_reg_pkg::ctrl_width-1:0] ctrl_q;
    logic [uart_reg_pkg::div_width-1:0]  div_q;
    logic [uart_reg_pkg::stat_width-1:0] stat;
    logic                                frame_err_q;
    logic                                overrun_q;
    logic                                wr_ack;
    logic                                rd_ack;

    // ==================================================
    // Bus handshake, one ack then one idle cycle
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wb_ack <= 1'b0;
        else
            wb_ack <= wb_cyc && wb_stb && !wb_ack;
    end

    assign wr_ack  = wb_ack && wb_we;
    assign rd_ack  = wb_ack && !wb_we;
    assign tx_push = wr_ack && (wb_adr == uart_reg_pkg::reg_data);  // FIFO drops it when full
    assign tx_data = wb_dat_w[uart_line_pkg::data_bits-1:0];
    assign rx_pop  = rd_ack && (wb_adr == uart_reg_pkg::reg_data);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q      <= '0;
            div_q       <= uart_reg_pkg::div_reset;
            frame_err_q <= 1'b0;
            overrun_q   <= 1'b0;
        end else begin
            if (wr_ack && wb_adr == uart_reg_pkg::reg_ctrl)
                ctrl_q <= wb_dat_w[uart_reg_pkg::ctrl_width-1:0];
            if (wr_ack && wb_adr == uart_reg_pkg::reg_div)
                div_q <= wb_dat_w[uart_reg_pkg::div_width-1:0];
            if (wr_ack && wb_adr == uart_reg_pkg::reg_stat) begin
                if (wb_dat_w[uart_reg_pkg::stat_frame_err])
                    frame_err_q <= 1'b0;
                if (wb_dat_w[uart_reg_pkg::stat_overrun])
                    overrun_q <= 1'b0;
            end
            // Sets win over a clear in the same cycle
            if (rx_pop && !rx_empty && rx_head.frame_err)
                frame_err_q <= 1'b1;
            if (rx_push && rx_full)
                overrun_q <= 1'b1;
        end
    end

    always_comb begin
        stat = '0;
        stat[uart_reg_pkg::stat_rx_avail]  = !rx_empty;
        stat[uart_reg_pkg::stat_tx_empty]  = tx_empty;
        stat[uart_reg_pkg::stat_tx_full]   = tx_full;
        stat[uart_reg_pkg::stat_rx_full]   = rx_full;
        stat[uart_reg_pkg::stat_frame_err] = frame_err_q;
        stat[uart_reg_pkg::stat_overrun]   = overrun_q;
    end

    // Read mux, valid during ack
    always_comb begin
        wb_dat_r = '0;
        case (wb_adr)
            uart_reg_pkg::reg_data:
                if (!rx_empty)
                    wb_dat_r[uart_line_pkg::data_bits-1:0] = rx_head.data;
            uart_reg_pkg::reg_stat: wb_dat_r[uart_reg_pkg::stat_width-1:0] = stat;
            uart_reg_pkg::reg_ctrl: wb_dat_r[uart_reg_pkg::ctrl_width-1:0] = ctrl_q;
            uart_reg_pkg::reg_div:  wb_dat_r[uart_reg_pkg::div_width-1:0]  = div_q;
            default: ;
        endcase
    end

    assign divisor = div_q;
    assign tx_en   = ctrl_q[uart_reg_pkg::ctrl_tx_en];
    assign rx_en   = ctrl_q[uart_reg_pkg::ctrl_rx_en];
    assign irq     = !rx_empty && ctrl_q[uart_reg_pkg::ctrl_irq_en];

    a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack);

endmodule

//--- verif/uart_tb.sv
// Testbench for the Wishbone UART peripheral
// Covers reset state, TX framing, loopback with irq, TX back-pressure, frame error and overrun

`timescale 1ns/1ps

module uart_tb;

    localparam int tb_div     = 1;
    localparam int bit_clks   = uart_line_pkg::oversample * (tb_div + 1);  // 32 clocks
    localparam int depth      = uart_line_pkg::fifo_depth;
    localparam int wait_limit = 4000;

    localparam logic [31:0] s_rx_avail  = 32'd1 << uart_reg_pkg::stat_rx_avail;
    localparam logic [31:0] s_tx_empty  = 32'd1 << uart_reg_pkg::stat_tx_empty;
    localparam logic [31:0] s_tx_full   = 32'd1 << uart_reg_pkg::stat_tx_full;
    localparam logic [31:0] s_rx_full   = 32'd1 << uart_reg_pkg::stat_rx_full;
    localparam logic [31:0] s_frame_err = 32'd1 << uart_reg_pkg::stat_frame_err;
    localparam logic [31:0] s_overrun   = 32'd1 << uart_reg_pkg::stat_overrun;
    localparam logic [31:0] c_tx_en     = 32'd1 << uart_reg_pkg::ctrl_tx_en;
    localparam logic [31:0] c_rx_en     = 32'd1 << uart_reg_pkg::ctrl_rx_en;
    localparam logic [31:0] c_irq_en    = 32'd1 << uart_reg_pkg::ctrl_irq_en;

    logic                               clk;
    logic                               rst_n;
    logic                               wb_cyc;
    logic                               wb_stb;
    logic                               wb_we;
    logic [uart_reg_pkg::adr_width-1:0] wb_adr;
    logic [31:0]                        wb_dat_w;
    logic [31:0]                        wb_dat_r;
    logic                               wb_ack;
    logic                               rx;
    logic                               rx_drv;
    logic                               tx;
    logic                               irq;
    logic                               loopback;
    logic                               irq_en_seen;
    logic [31:0]                        lfsr;

    assign rx = loopback ? tx : rx_drv;

    uart_top dut_i (
        .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .rx, .tx, .irq
    );

    always #5 clk = ~clk;

    // ==================================================
    // Failure reporting and value checks
    // ==================================================
    task automatic end_with_failure();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        end_with_failure();
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
            end_with_failure();
        end
    endtask

    // Bus side model of CTRL irq_en, updated on the acknowledge cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            irq_en_seen <= 1'b0;
        else if (wb_ack && wb_we && wb_adr == uart_reg_pkg::reg_ctrl)
            irq_en_seen <= wb_dat_w[uart_reg_pkg::ctrl_irq_en];
    end

    a_ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else report_failure("wb_ack stayed high for more than one cycle");

    a_ack_requested: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else report_failure("wb_ack came without a bus request");

    a_irq_enabled: assert property (@(posedge clk) disable iff (!rst_n)
        irq |-> irq_en_seen)
        else report_failure("irq was raised while interrupts were disabled");

    // ==================================================
    // Helpers, all called one ns after a rising edge
    // ==================================================
    task automatic wait_clocks(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic next_random_byte(output logic [7:0] b);
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            b    = {b[6:0], lfsr[0]};
        end
    endtask

    task automatic wb_write(input logic [3:0] adr, input logic [31:0] data);
        int n;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        n = 0;
        do begin
            wait_clocks(1);
            n++;
        end while (!wb_ack && n < 20);
        if (!wb_ack)
            report_failure("bus write got no acknowledge");
        wait_clocks(1);   // Hold through the acknowledge edge
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [31:0] data);
        int n;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        n = 0;
        do begin
            wait_clocks(1);
            n++;
        end while (!wb_ack && n < 20);
        if (!wb_ack)
            report_failure("bus read got no acknowledge");
        data   = wb_dat_r;   // Valid while ack is high
        wait_clocks(1);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic wait_stat_bit(input logic [31:0] mask, input string what);
        logic [31:0] st;
        int          n;
        n = 0;
        do begin
            wb_read(uart_reg_pkg::reg_stat, st);
            n++;
        end while (!(st & mask) && n < wait_limit / 4);
        if (!(st & mask))
            report_failure({"STAT never showed ", what});
    endtask

    task automatic send_frame(input logic [7:0] data, input logic stop);
        rx_drv = 1'b0;
        wait_clocks(bit_clks);
        for (int i = 0; i < 8; i++) begin
            rx_drv = data[i];   // LSB first
            wait_clocks(bit_clks);
        end
        rx_drv = stop;
        wait_clocks(bit_clks);
        rx_drv = 1'b1;
        wait_clocks(bit_clks);
    endtask

    // Finds the start bit, then samples each bit at its middle
    task automatic capture_frame(output logic [7:0] data, output logic stop);
        int n;
        n = 0;
        while (tx && n < wait_limit) begin
            wait_clocks(1);
            n++;
        end
        if (tx)
            report_failure("no start bit appeared on tx");
        wait_clocks(bit_clks / 2);
        check_eq("start bit mid-point", 0, tx);
        for (int i = 0; i < 8; i++) begin
            wait_clocks(bit_clks);
            data[i] = tx;
        end
        wait_clocks(bit_clks);
        stop = tx;
    endtask

    task automatic expect_line_idle(input int n_clks);
        for (int i = 0; i < n_clks; i++) begin
            if (!tx)
                report_failure("tx left idle after the TX FIFO drained");
            wait_clocks(1);
        end
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        logic [31:0] rd;
        logic [7:0]  sent [depth+1];
        logic [7:0]  got;
        logic        stop;
        clk      = 1'b0;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        rx_drv   = 1'b1;
        loopback = 1'b0;
        lfsr     = 32'h78ba_5ffa;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        wait_clocks(2);

        // 1. Reset state
        check_eq("reset tx", 1, tx);
        check_eq("reset irq", 0, irq);
        wb_read(uart_reg_pkg::reg_stat, rd);
        check_eq("reset STAT", s_tx_empty, rd);
        wb_read(uart_reg_pkg::reg_ctrl, rd);
        check_eq("reset CTRL", 0, rd);
        wb_read(uart_reg_pkg::reg_div, rd);
        check_eq("reset DIV", 32'(uart_reg_pkg::div_reset), rd);

        // 2. Transmit framing
        wb_write(uart_reg_pkg::reg_div, tb_div);
        wb_write(uart_reg_pkg::reg_ctrl, c_tx_en);
        next_random_byte(sent[0]);
        wb_write(uart_reg_pkg::reg_data, 32'(sent[0]));
        capture_frame(got, stop);
        check_eq("tx framing data", 32'(sent[0]), 32'(got));
        check_eq("tx framing stop", 1, stop);

        // 3. Loopback order and interrupt
        loopback = 1'b1;
        wb_write(uart_reg_pkg::reg_ctrl, c_tx_en | c_rx_en | c_irq_en);
        check_eq("irq before any frame", 0, irq);
        for (int i = 0; i < depth; i++) begin
            next_random_byte(sent[i]);
            wb_write(uart_reg_pkg::reg_data, 32'(sent[i]));
        end
        for (int n = 0; !irq; n++) begin
            if (n >= wait_limit)
                report_failure("irq did not rise with received data waiting");
            wait_clocks(1);
        end
        wait_stat_bit(s_rx_full, "rx_full after loopback frames");
        for (int i = 0; i < depth; i++) begin
            wb_read(uart_reg_pkg::reg_data, rd);
            check_eq($sformatf("loopback byte %0d", i), 32'(sent[i]), rd);
        end
        check_eq("irq after drain", 0, irq);
        wb_read(uart_reg_pkg::reg_data, rd);
        check_eq("empty DATA read", 0, rd);
        wait_clocks(bit_clks);
        loopback = 1'b0;

        // 4. TX back-pressure
        wb_write(uart_reg_pkg::reg_ctrl, 0);
        for (int i = 0; i <= depth; i++) begin
            next_random_byte(sent[i]);
            wb_write(uart_reg_pkg::reg_data, 32'(sent[i]));
        end
        wb_read(uart_reg_pkg::reg_stat, rd);
        check_eq("STAT with TX FIFO full", s_tx_full, rd);
        wb_write(uart_reg_pkg::reg_ctrl, c_tx_en);
        for (int i = 0; i < depth; i++) begin
            capture_frame(got, stop);
            check_eq($sformatf("back-pressure byte %0d", i), 32'(sent[i]), 32'(got));
            check_eq($sformatf("back-pressure stop %0d", i), 1, stop);
        end
        expect_line_idle(2 * 10 * bit_clks);
        wb_read(uart_reg_pkg::reg_stat, rd);
        check_eq("STAT after TX drain", s_tx_empty, rd);

        // 5. Framing error
        wb_write(uart_reg_pkg::reg_ctrl, c_rx_en);
        next_random_byte(sent[0]);
        send_frame(sent[0], 1'b0);
        wait_stat_bit(s_rx_avail, "rx_avail after bad frame");
        wb_read(uart_reg_pkg::reg_data, rd);
        check_eq("frame error data", 32'(sent[0]), rd);
        wb_read(uart_reg_pkg::reg_stat, rd);
        check_eq("STAT with frame_err", s_tx_empty | s_frame_err, rd);
        wb_write(uart_reg_pkg::reg_stat, s_frame_err | s_overrun);
        wb_read(uart_reg_pkg::reg_stat, rd);
        check_eq("STAT after flag clear", s_tx_empty, rd);

        // 6. Overrun
        for (int i = 0; i <= depth; i++) begin
            next_random_byte(sent[i]);
            send_frame(sent[i], 1'b1);
        end
        wait_stat_bit(s_overrun, "overrun after extra frame");
        wb_read(uart_reg_pkg::reg_stat, rd);
        check_eq("STAT with overrun", s_rx_avail | s_tx_empty | s_rx_full | s_overrun, rd);
        for (int i = 0; i < depth; i++) begin
            wb_read(uart_reg_pkg::reg_data, rd);
            check_eq($sformatf("overrun byte %0d", i), 32'(sent[i]), rd);
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule
